//--- logic/access_stage_ctrl.sv
`timescale 1ns/100ps

module access_stage_ctrl (
    input  controller_pkg::ctrl_state_t  state,
    input  controller_pkg::instr_class_t iclass,
    input  controller_pkg::opcode_t      opcode,
    input  controller_pkg::mem_mode_t    mem_mode,
    input  logic                         literal_load,
    input  logic                         en_status_decode,
    input  logic                         branch_taken,
    output controller_pkg::exec_ctrl_t   exec,
    output controller_pkg::pc_ctrl_t     pc,
    output controller_pkg::wb_ctrl_t     wb,
    output logic                         ram_w_en
);
    import controller_pkg::*;

    alu_op_t data_alu_op;

    // data processing op from the low three opcode bits
    always_comb begin
        case (opcode[2:0])
            3'b000:  data_alu_op = alu_add;
            3'b001:  data_alu_op = alu_sub;
            3'b010:  data_alu_op = alu_sub;
            3'b011:  data_alu_op = alu_and;
            3'b100:  data_alu_op = alu_orr;
            3'b101:  data_alu_op = alu_xor;
            default: data_alu_op = alu_add;
        endcase
    end

    always_comb begin
        exec     = '0;
        pc       = '0;
        wb       = '0;
        ram_w_en = 1'b0;

        case (state)
            load_pc_start: begin
                pc.load_pc = 1'b1;
                pc.sel_pc  = pc_start;
            end
            memory_increment_pc: begin
                // result register latches every instruction
                exec.en_c = 1'b1;
                if (iclass != cls_none) begin
                    pc.load_pc = 1'b1;
                    pc.sel_pc  = pc_increment;
                end

                case (iclass)
                    cls_data: begin
                        exec.alu_op = data_alu_op;
                        // immediate path when register not read
                        exec.sel_a     = !opcode[3];
                        exec.sel_b     = !opcode[4];
                        exec.en_status = en_status_decode;
                        // compare only sets flags
                        wb.w_en1 = (opcode[3:0] != cmp_low_bits);
                    end
                    cls_mem: begin
                        if (mem_mode.up) begin
                            exec.alu_op = alu_add;
                        end else begin
                            exec.alu_op = alu_sub;
                        end
                        exec.sel_b             = !opcode[3];
                        exec.sel_post_indexing = !mem_mode.pre_index;
                        exec.en_status         = en_status_decode;
                        // base update on post index or explicit W
                        wb.w_en2 = !mem_mode.pre_index || mem_mode.write_back;
                        // bit 4 marks a store
                        ram_w_en = opcode[4];
                    end
                    cls_branch: begin
                        if (branch_taken) begin
                            pc.sel_pc = pc_branch;
                        end
                        exec.alu_op = alu_add;
                        // target relative to PC
                        exec.sel_a = 1'b1;
                        exec.sel_b = !opcode[1];
                        // link writes return address to LR
                        if (opcode[2]) begin
                            wb.w_en1       = 1'b1;
                            wb.sel_w_addr1 = 1'b1;
                        end
                    end
                    default: begin
                        exec.alu_op = alu_add;
                    end
                endcase
            end
            write_back: begin
                // loaded word goes back through port 3
                if (iclass == cls_mem) begin
                    wb.w_en3 = (opcode[6:4] == 3'b110) || literal_load;
                end
            end
            default: begin
                pc.load_pc = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/branch_cond_eval.sv
`timescale 1ns/100ps

module branch_cond_eval (
    input  controller_pkg::cond_t cond,
    input  controller_pkg::word_t status_reg,
    output logic                  branch_taken
);
    logic n;
    logic z;
    logic c;
    logic v;

    assign n = status_reg[31];
    assign z = status_reg[30];
    assign c = status_reg[29];
    assign v = status_reg[28];

    always_comb begin
        case (cond)
            4'd0:    branch_taken = z;
            4'd1:    branch_taken = !z;
            4'd2:    branch_taken = c;
            4'd3:    branch_taken = !c;
            4'd4:    branch_taken = n;
            4'd5:    branch_taken = !n;
            4'd6:    branch_taken = v;
            4'd7:    branch_taken = !v;
            // unsigned higher
            4'd8:    branch_taken = c && !z;
            // unsigned lower or same
            4'd9:    branch_taken = !c || z;
            // signed compares
            4'd10:   branch_taken = (n == v);
            4'd11:   branch_taken = (n != v);
            4'd12:   branch_taken = !z && (n == v);
            4'd13:   branch_taken = z || (n != v);
            4'd14:   branch_taken = 1'b1;
            // 15 never branches
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- logic/controller.sv
`timescale 1ns/100ps

module controller (
    input  logic                          clk,
    input  logic                          rst_n,
    input  controller_pkg::opcode_t       opcode,
    input  controller_pkg::cond_t         cond,
    input  controller_pkg::word_t         status_reg,
    input  controller_pkg::mem_mode_t     mem_mode,
    input  logic                          en_status_decode,
    output logic                          load_ir,
    output logic                          status_rdy,
    output controller_pkg::operand_ctrl_t operand,
    output controller_pkg::exec_ctrl_t    exec,
    output controller_pkg::pc_ctrl_t      pc,
    output controller_pkg::wb_ctrl_t      wb,
    output logic                          ram_w_en
);
    import controller_pkg::*;

    ctrl_state_t  state;
    instr_class_t iclass;
    logic         literal_load;
    logic         branch_taken;

    state_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .load_ir    (load_ir),
        .status_rdy (status_rdy)
    );

    instr_classifier u_class (
        .opcode       (opcode),
        .cond         (cond),
        .iclass       (iclass),
        .literal_load (literal_load)
    );

    branch_cond_eval u_cond (
        .cond         (cond),
        .status_reg   (status_reg),
        .branch_taken (branch_taken)
    );

    operand_stage_ctrl u_operand (
        .state   (state),
        .iclass  (iclass),
        .opcode  (opcode),
        .operand (operand)
    );

    access_stage_ctrl u_access (
        .state            (state),
        .iclass           (iclass),
        .opcode           (opcode),
        .mem_mode         (mem_mode),
        .literal_load     (literal_load),
        .en_status_decode (en_status_decode),
        .branch_taken     (branch_taken),
        .exec             (exec),
        .pc               (pc),
        .wb               (wb),
        .ram_w_en         (ram_w_en)
    );

endmodule

//--- logic/controller_pkg.sv
package controller_pkg;

    // instruction fields
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  cond_t;

    // status word, flags N Z C V live in bits 31..28
    typedef logic [31:0] word_t;

    // step encodings, load_pc_start sits after the loop
    typedef enum logic [3:0] {
        reset               = 4'd0,
        fetch               = 4'd1,
        fetch_wait          = 4'd2,
        decode              = 4'd3,
        execute             = 4'd4,
        memory_increment_pc = 4'd5,
        memory_wait         = 4'd6,
        write_back          = 4'd7,
        load_pc_start       = 4'd8
    } ctrl_state_t;

    typedef enum logic [1:0] {
        cls_none   = 2'd0,
        cls_data   = 2'd1,
        cls_mem    = 2'd2,
        cls_branch = 2'd3
    } instr_class_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_orr = 3'b011,
        alu_xor = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        pc_increment = 2'b00,
        pc_start     = 2'b01,
        pc_branch    = 2'b11
    } sel_pc_t;

    // load/store addressing bits P U W
    typedef struct packed {
        logic pre_index;
        logic up;
        logic write_back;
    } mem_mode_t;

    // operand register stage
    typedef struct packed {
        logic en_a;
        logic en_b;
        logic en_s;
        logic sel_shift;
    } operand_ctrl_t;

    // execute stage and result register
    typedef struct packed {
        logic    sel_a;
        logic    sel_b;
        logic    sel_post_indexing;
        alu_op_t alu_op;
        logic    en_status;
        logic    en_c;
    } exec_ctrl_t;

    typedef struct packed {
        logic    load_pc;
        sel_pc_t sel_pc;
    } pc_ctrl_t;

    // register file write ports
    typedef struct packed {
        logic w_en1;
        logic w_en2;
        logic w_en3;
        logic forward_w_data;
        logic sel_w_addr1;
    } wb_ctrl_t;

    // low opcode nibble of a compare, no result written
    localparam logic [3:0] cmp_low_bits = 4'b1010;

endpackage

//--- logic/instr_classifier.sv
`timescale 1ns/100ps

module instr_classifier (
    input  controller_pkg::opcode_t      opcode,
    input  controller_pkg::cond_t        cond,
    output controller_pkg::instr_class_t iclass,
    output logic                         literal_load
);
    import controller_pkg::*;

    logic is_data;
    logic is_mem;
    logic is_branch;

    // cond 1111 on a data opcode is treated as no instruction
    assign is_data = !opcode[6] && (cond != 4'b1111);

    // PC relative literal load
    assign literal_load = (opcode[6:3] == 4'b1000);

    assign is_mem    = (opcode[6:5] == 2'b11) || literal_load;
    assign is_branch = (opcode[6:3] == 4'b1001);

    always_comb begin
        if (is_data) begin
            iclass = cls_data;
        end else if (is_mem) begin
            iclass = cls_mem;
        end else if (is_branch) begin
            iclass = cls_branch;
        end else begin
            iclass = cls_none;
        end
    end

endmodule

//--- logic/operand_stage_ctrl.sv
`timescale 1ns/100ps

module operand_stage_ctrl (
    input  controller_pkg::ctrl_state_t   state,
    input  controller_pkg::instr_class_t  iclass,
    input  controller_pkg::opcode_t       opcode,
    output controller_pkg::operand_ctrl_t operand
);
    import controller_pkg::*;

    // operand registers load only in execute
    always_comb begin
        operand = '0;
        if (state == execute) begin
            case (iclass)
                cls_data: begin
                    // bit 3 reads Rn, bit 4 reads Rm
                    operand.en_a = opcode[3];
                    operand.en_b = opcode[4];
                    operand.en_s = 1'b1;
                    // immediate form loads a zero shift
                    if (opcode[4]) begin
                        operand.sel_shift = opcode[5];
                    end else begin
                        operand.sel_shift = 1'b0;
                    end
                end
                cls_mem: begin
                    // base register is always read
                    operand.en_a = 1'b1;
                    // register offset
                    operand.en_b      = opcode[3];
                    operand.en_s      = opcode[3];
                    operand.sel_shift = 1'b0;
                end
                cls_branch: begin
                    operand.en_a      = 1'b0;
                    // register target in Rm
                    operand.en_b      = opcode[1];
                    operand.en_s      = 1'b1;
                    operand.sel_shift = 1'b1;
                end
                default: begin
                    operand = '0;
                end
            endcase
        end
    end

endmodule

//--- logic/state_sequencer.sv
`timescale 1ns/100ps

module state_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    output controller_pkg::ctrl_state_t state,
    output logic                      load_ir,
    output logic                      status_rdy
);
    import controller_pkg::*;

    ctrl_state_t next_state;

    // one pass through load_pc_start, then the seven step loop
    always_comb begin
        case (state)
            reset:               next_state = load_pc_start;
            load_pc_start:       next_state = fetch;
            fetch:               next_state = fetch_wait;
            fetch_wait:          next_state = decode;
            decode:              next_state = execute;
            execute:             next_state = memory_increment_pc;
            memory_increment_pc: next_state = memory_wait;
            memory_wait:         next_state = write_back;
            write_back:          next_state = fetch;
            // illegal code, start over
            default:             next_state = reset;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= reset;
        end else begin
            state <= next_state;
        end
    end

    // instruction word is on the memory bus in decode
    assign load_ir = (state == decode);

    // flags from execute are settled by memory_wait
    assign status_rdy = (state == memory_wait);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_controller -f src.f --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb

//--- src.f
+incdir+verification
logic/controller_pkg.sv
logic/state_sequencer.sv
logic/instr_classifier.sv
logic/branch_cond_eval.sv
logic/operand_stage_ctrl.sv
logic/access_stage_ctrl.sv
logic/controller.sv
verification/tb_controller.sv

//--- verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic          load_ir;
    logic          status_rdy;
    operand_ctrl_t operand;
    exec_ctrl_t    exec;
    pc_ctrl_t      pc;
    wb_ctrl_t      wb;
    logic          ram_w_en;
} expected_t;

// codes come in pairs, the odd one inverts the even test
function automatic logic cond_holds(input cond_t cd, input word_t sr);
    logic base;
    case (cd[3:1])
        3'd0:    base = sr[30];
        3'd1:    base = sr[29];
        3'd2:    base = sr[31];
        3'd3:    base = sr[28];
        3'd4:    base = sr[29] && !sr[30];
        3'd5:    base = (sr[31] == sr[28]);
        3'd6:    base = !sr[30] && (sr[31] == sr[28]);
        default: base = 1'b1;
    endcase
    return base ^ cd[0];
endfunction

function automatic expected_t ref_outputs(input ctrl_state_t step, input opcode_t op,
        input cond_t cd, input word_t sr, input mem_mode_t mm, input logic esd);
    expected_t    e;
    logic         is_lit;
    instr_class_t cls;
    e = '0;
    is_lit = (op[6:3] == 4'b1000);
    cls = (!op[6] && cd != 4'hf) ? cls_data :
          (op[6:5] == 2'b11 || is_lit) ? cls_mem :
          (op[6:3] == 4'b1001) ? cls_branch : cls_none;
    e.load_ir    = (step == decode);
    e.status_rdy = (step == memory_wait);
    case (step)
        load_pc_start: begin
            e.pc.load_pc = 1'b1;
            e.pc.sel_pc  = pc_start;
        end
        // en_a, en_b, en_s, sel_shift
        execute: begin
            case (cls)
                cls_data:   e.operand = {op[3], op[4], 1'b1, op[4] & op[5]};
                cls_mem:    e.operand = {1'b1, op[3], op[3], 1'b0};
                cls_branch: e.operand = {1'b0, op[1], 2'b11};
                default:    e.operand = '0;
            endcase
        end
        memory_increment_pc: begin
            e.exec.en_c  = 1'b1;
            e.pc.load_pc = (cls != cls_none);
            e.pc.sel_pc  = (cls == cls_branch && cond_holds(cd, sr)) ? pc_branch : pc_increment;
            case (cls)
                cls_data: begin
                    case (op[2:0])
                        3'b001, 3'b010: e.exec.alu_op = alu_sub;
                        3'b011:         e.exec.alu_op = alu_and;
                        3'b100:         e.exec.alu_op = alu_orr;
                        3'b101:         e.exec.alu_op = alu_xor;
                        default:        e.exec.alu_op = alu_add;
                    endcase
                    e.exec.sel_a     = !op[3];
                    e.exec.sel_b     = !op[4];
                    e.exec.en_status = esd;
                    e.wb.w_en1       = (op[3:0] != cmp_low_bits);
                end
                cls_mem: begin
                    e.exec.alu_op            = mm.up ? alu_add : alu_sub;
                    e.exec.sel_b             = !op[3];
                    e.exec.sel_post_indexing = !mm.pre_index;
                    e.exec.en_status         = esd;
                    e.wb.w_en2               = !mm.pre_index || mm.write_back;
                    e.ram_w_en               = op[4];
                end
                cls_branch: begin
                    e.exec.sel_a     = 1'b1;
                    e.exec.sel_b     = !op[1];
                    e.wb.w_en1       = op[2];
                    e.wb.sel_w_addr1 = op[2];
                end
                default: ;
            endcase
        end
        // loads only, plain or literal
        write_back: e.wb.w_en3 = (cls == cls_mem) && (op[6:4] == 3'b110 || is_lit);
        default: ;
    endcase
    return e;
endfunction

`endif

//--- verification/tb_controller.sv
`timescale 1ns/100ps

module tb_controller;
    import controller_pkg::*;

    `include "tb_ref_model.svh"

    typedef struct packed {
        opcode_t   op;
        cond_t     cd;
        mem_mode_t mm;
        logic      esd;
        word_t     sr;
    } stim_t;

    logic          clk;
    logic          rst_n;
    opcode_t       opcode;
    cond_t         cond;
    word_t         status_reg;
    mem_mode_t     mem_mode;
    logic          en_status_decode;
    logic          load_ir;
    logic          status_rdy;
    operand_ctrl_t operand;
    exec_ctrl_t    exec;
    pc_ctrl_t      pc;
    wb_ctrl_t      wb;
    logic          ram_w_en;

    integer    seed = 47666;
    int        cyc = 0;
    int        issued = 0;
    int        retired = 0;
    stim_t     stim_q [$];
    expected_t exp_now;

    controller UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cycle count since reset release to step
    function automatic ctrl_state_t step_at(input int n);
        ctrl_state_t loop_steps [7] = '{fetch, fetch_wait, decode, execute,
                                        memory_increment_pc, memory_wait, write_back};
        if (n == 0) begin
            return reset;
        end
        return (n == 1) ? load_pc_start : loop_steps[(n - 2) % 7];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic add_instr(input opcode_t op, input cond_t cd, input word_t sr,
            input mem_mode_t mm, input logic esd);
        stim_q.push_back('{op: op, cd: cd, mm: mm, esd: esd, sr: sr});
    endtask

    task automatic build_stimulus();
        logic [31:0] r;
        // data processing with some forced compares
        for (int k = 0; k < 48; k++) begin
            r = $random(seed);
            add_instr({1'b0, r[5:4], (k % 12 == 0) ? cmp_low_bits : r[3:0]},
                      cond_t'(r[11:8] % 4'd15), r, mem_mode_t'(r[14:12]), r[15]);
        end
        // every P U W with both offsets for loads and stores
        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            add_instr({2'b11, k[4], k[3], r[2:0]}, r[11:8], r, mem_mode_t'(k[2:0]), r[15]);
        end
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            add_instr({4'b1000, r[2:0]}, r[11:8], r, mem_mode_t'(r[14:12]), r[15]);
        end
        // all conditions with and without link
        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            add_instr({4'b1001, k[4], r[1:0]}, k[3:0], r, mem_mode_t'(r[14:12]), r[15]);
        end
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            if (k < 4) begin
                add_instr({1'b0, r[5:0]}, 4'hf, r, mem_mode_t'(r[14:12]), r[15]);
            end else begin
                add_instr({3'b101, r[3:0]}, r[11:8], r, mem_mode_t'(r[14:12]), r[15]);
            end
        end
    endtask

    // phase counter and new inputs on the edge that enters fetch
    always @(posedge clk) begin
        if (rst_n) begin
            cyc <= cyc + 1;
            if (cyc >= 1 && (cyc - 1) % 7 == 0 && issued < stim_q.size()) begin
                opcode           <= stim_q[issued].op;
                cond             <= stim_q[issued].cd;
                status_reg       <= stim_q[issued].sr;
                mem_mode         <= stim_q[issued].mm;
                en_status_decode <= stim_q[issued].esd;
                issued           <= issued + 1;
            end
        end
    end

    always @(negedge clk) begin
        exp_now = ref_outputs(step_at(cyc), opcode, cond, status_reg, mem_mode, en_status_decode);
        check_value("load_ir", 32'(load_ir), 32'(exp_now.load_ir));
        check_value("status_rdy", 32'(status_rdy), 32'(exp_now.status_rdy));
        check_value("operand", 32'(operand), 32'(exp_now.operand));
        check_value("exec", 32'(exec), 32'(exp_now.exec));
        check_value("pc", 32'(pc), 32'(exp_now.pc));
        check_value("wb", 32'(wb), 32'(exp_now.wb));
        check_value("ram_w_en", 32'(ram_w_en), 32'(exp_now.ram_w_en));
        if (step_at(cyc) == write_back) begin
            retired = retired + 1;
        end
    end

    initial begin
        int waited;
        rst_n            = 1'b0;
        opcode           = '0;
        cond             = '0;
        status_reg       = '0;
        mem_mode         = '0;
        en_status_decode = 1'b0;
        build_stimulus();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        waited = 0;
        while (retired < stim_q.size() && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        if (retired == stim_q.size()) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("timeout: only %0d of %0d instructions completed", retired, stim_q.size());
            $display("FAIL: see errors above");
            $fatal(1, "watchdog timeout");
        end
    end

endmodule
